// File: logic/bp_macros.svh
// sizes shared by the branch predictor RTL and its testbench
// OBQ_DEPTH must be a power of two since queue pointers wrap by overflow
// BH_SIZE must be at least 2 and at most XLEN-2

`ifndef BP_MACROS_SVH
`define BP_MACROS_SVH

// global history length, also the pattern table index width
`define BH_SIZE 8

// in-flight branches the ordered queue can hold
`define OBQ_DEPTH 4

// pc and instruction word width
`define XLEN 32

`endif

// File: logic/bp_pkg.sv
// types shared by decoder, gshare core and branch queue
// field layout of instr_word_u follows the rv32 b-type encoding

`include "bp_macros.svh"

package bp_pkg;

	// opcode-only view of a fetched word
	typedef struct packed {
		logic [`XLEN-8:0] upper; // everything above the opcode
		logic [6:0]       opcode;
	} instr_raw_t;

	// b-type field view, msb first
	typedef struct packed {
		logic       imm12;   // sign bit of the offset
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} instr_btype_t;

	// one instruction word read two ways
	typedef union packed {
		instr_raw_t   raw;
		instr_btype_t b;
	} instr_word_u;

	typedef struct packed {
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] target; // pc + b-type offset
	} fetch_branch_t;

	typedef struct packed {
		logic                taken;
		logic [`XLEN-1:0]    next_pc;
		logic [`BH_SIZE-1:0] history; // ghr before this branch was shifted in
	} prediction_t;

	typedef struct packed {
		logic [`XLEN-1:0]    pc;
		logic [`BH_SIZE-1:0] history;
		logic                taken;        // predicted direction
		logic [`XLEN-1:0]    fall_through; // pc + 4
		logic [`XLEN-1:0]    target;
	} obq_entry_t;

	typedef struct packed {
		logic [`XLEN-1:0]    pc;
		logic [`BH_SIZE-1:0] history;
		logic                taken; // actual outcome
	} rollback_t;

endpackage

// File: logic/branch_decoder.sv
// one fetched word per cycle, outputs are registered one cycle later
// only opcode 1100011 counts as a branch, jal/jalr are not recognized

`timescale 1ns/1ps
`include "bp_macros.svh"

module branch_decoder (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  fetch_valid,
	input  logic [`XLEN-1:0]      fetch_pc,
	input  bp_pkg::instr_word_u   fetch_instr,
	output logic                  branch_valid,
	output bp_pkg::fetch_branch_t branch
);
	import bp_pkg::*;

	localparam logic [6:0] OPCODE_BRANCH = 7'b1100011; // beq bne blt bge bltu bgeu

	logic             is_branch;
	logic [`XLEN-1:0] imm_b;       // sign-extended byte offset
	fetch_branch_t    branch_next;

	// opcode view decides if the word is a conditional branch
	assign is_branch = (fetch_instr.raw.opcode == OPCODE_BRANCH);

	// field view gives the scattered offset bits, bit 0 is implied zero
	assign imm_b = {
		{(`XLEN-12){fetch_instr.b.imm12}},
		fetch_instr.b.imm11,
		fetch_instr.b.imm10_5,
		fetch_instr.b.imm4_1,
		1'b0
	};

	always_comb begin
		branch_next.pc     = fetch_pc;
		branch_next.target = fetch_pc + imm_b; // pc-relative taken target
	end

	// strobe register
	always_ff @(posedge clock) begin
		if (reset) begin
			branch_valid <= 1'b0;
		end else begin
			branch_valid <= fetch_valid & is_branch; // non-branch words never reach gshare
		end
	end

	// payload is only meaningful while branch_valid is high
	always_ff @(posedge clock) begin
		if (fetch_valid) begin
			branch <= branch_next;
		end
	end

endmodule

// File: logic/gshare_predictor.sv
// one-bit gshare with a single speculative history register
// rollback wins over a new request and updates land on the next edge

`timescale 1ns/1ps
`include "bp_macros.svh"

module gshare_predictor (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  branch_valid,
	input  bp_pkg::fetch_branch_t branch,
	input  logic                  queue_full,
	input  logic                  rollback_valid,
	input  bp_pkg::rollback_t     rollback,
	output logic                  pred_valid,
	output bp_pkg::prediction_t   prediction
);

	localparam int PHT_SIZE = 1 << `BH_SIZE;

	logic [PHT_SIZE-1:0] pht;      // 1 = taken, cleared to not taken at reset
	logic [PHT_SIZE-1:0] pht_next;
	logic [`BH_SIZE-1:0] ghr;      // speculative global history, newest in bit 0
	logic [`BH_SIZE-1:0] ghr_next;
	logic [`BH_SIZE-1:0] pred_idx;
	logic [`BH_SIZE-1:0] fix_idx;
	logic                pred_taken;

	// hash with word-address bits, byte offset dropped
	assign pred_idx   = ghr ^ branch.pc[`BH_SIZE+1:2];
	assign fix_idx    = rollback.history ^ rollback.pc[`BH_SIZE+1:2];
	assign pred_taken = pht[pred_idx];

	// no slot in the queue or a rollback in flight means no prediction
	assign pred_valid = branch_valid & ~queue_full & ~rollback_valid;

	always_comb begin
		prediction.taken   = pred_taken;
		prediction.next_pc = pred_taken ? branch.target : branch.pc + `XLEN'd4;
		prediction.history = ghr; // checkpoint taken before the shift
	end

	always_comb begin
		pht_next = pht;
		ghr_next = ghr;
		if (rollback_valid) begin
			// restore the mispredicted branch's history with its real outcome
			ghr_next          = {rollback.history[`BH_SIZE-2:0], rollback.taken};
			pht_next[fix_idx] = ~pht[fix_idx]; // one-bit entry, flip it to the actual direction
		end else if (pred_valid) begin
			ghr_next = {ghr[`BH_SIZE-2:0], pred_taken}; // speculative shift
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			pht <= '0;
			ghr <= '0;
		end else begin
			pht <= pht_next;
			ghr <= ghr_next;
		end
	end

endmodule

// File: logic/branch_queue.sv
// in-order queue of predicted branches, resolutions must arrive in program order
// a resolve strobe with an empty queue is dropped
// a mispredict empties the whole queue at the next edge

`timescale 1ns/1ps
`include "bp_macros.svh"

module branch_queue (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  pred_valid,
	input  bp_pkg::fetch_branch_t branch,
	input  bp_pkg::prediction_t   prediction,
	input  logic                  resolve_valid,
	input  logic                  resolve_taken,
	output logic                  queue_full,
	output logic                  mispredict,
	output logic [`XLEN-1:0]      redirect_pc,
	output logic                  rollback_valid,
	output bp_pkg::rollback_t     rollback
);
	import bp_pkg::*;

	localparam int PTR_W = (`OBQ_DEPTH > 1) ? $clog2(`OBQ_DEPTH) : 1;
	localparam int CNT_W = PTR_W + 1;

	obq_entry_t       mem [`OBQ_DEPTH];
	obq_entry_t       head_entry;
	obq_entry_t       push_entry;
	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;
	logic [CNT_W-1:0] count;
	logic             empty;
	logic             push;
	logic             pop;

	assign empty      = (count == '0);
	assign queue_full = (count == CNT_W'(`OBQ_DEPTH));
	assign push       = pred_valid; // every prediction is queued in the cycle it is made
	assign pop        = resolve_valid & ~empty;
	assign head_entry = mem[head];

	always_comb begin
		push_entry.pc           = branch.pc;
		push_entry.history      = prediction.history;
		push_entry.taken        = prediction.taken;
		push_entry.fall_through = branch.pc + `XLEN'd4;
		push_entry.target       = branch.target;
	end

	// head check, same cycle as the resolve strobe
	assign mispredict  = pop & (resolve_taken != head_entry.taken);
	assign redirect_pc = resolve_taken ? head_entry.target : head_entry.fall_through;

	// rollback info goes straight back to gshare
	assign rollback_valid = mispredict;
	always_comb begin
		rollback.pc      = head_entry.pc;
		rollback.history = head_entry.history;
		rollback.taken   = resolve_taken;
	end

	// storage, written only at the tail
	always_ff @(posedge clock) begin
		if (push) begin
			mem[tail] <= push_entry;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else if (mispredict) begin
			// flush younger entries together with the resolved head
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (push) tail <= tail + 1'b1; // wraps since depth is a power of two
			if (pop) head <= head + 1'b1;
			count <= count + CNT_W'(push) - CNT_W'(pop);
		end
	end

endmodule

// File: logic/branch_predictor_top.sv
// decoder -> gshare -> ordered queue, queue feeds rollback back to gshare
// fetch and resolve are one-cycle strobes with no back-pressure to fetch

`timescale 1ns/1ps
`include "bp_macros.svh"

module branch_predictor_top (
	input  logic                clock,
	input  logic                reset,
	input  logic                fetch_valid,
	input  logic [`XLEN-1:0]    fetch_pc,
	input  bp_pkg::instr_word_u fetch_instr,
	input  logic                resolve_valid,
	input  logic                resolve_taken,
	output logic                prediction_valid,
	output logic                prediction_taken,
	output logic [`XLEN-1:0]    prediction_next_pc,
	output logic                mispredict,
	output logic [`XLEN-1:0]    redirect_pc,
	output logic                queue_full
);
	import bp_pkg::*;

	logic          branch_valid;
	fetch_branch_t branch;
	logic          pred_valid;
	prediction_t   prediction;
	logic          rollback_valid;
	rollback_t     rollback;

	branch_decoder branch_decoder_inst (
		.clock        (clock),
		.reset        (reset),
		.fetch_valid  (fetch_valid),
		.fetch_pc     (fetch_pc),
		.fetch_instr  (fetch_instr),
		.branch_valid (branch_valid),
		.branch       (branch)
	);

	gshare_predictor gshare_predictor_inst (
		.clock          (clock),
		.reset          (reset),
		.branch_valid   (branch_valid),
		.branch         (branch),
		.queue_full     (queue_full),
		.rollback_valid (rollback_valid),
		.rollback       (rollback),
		.pred_valid     (pred_valid),
		.prediction     (prediction)
	);

	branch_queue branch_queue_inst (
		.clock          (clock),
		.reset          (reset),
		.pred_valid     (pred_valid),
		.branch         (branch),
		.prediction     (prediction),
		.resolve_valid  (resolve_valid),
		.resolve_taken  (resolve_taken),
		.queue_full     (queue_full),
		.mispredict     (mispredict),
		.redirect_pc    (redirect_pc),
		.rollback_valid (rollback_valid),
		.rollback       (rollback)
	);

	// prediction goes out in the same cycle it is queued
	assign prediction_valid   = pred_valid;
	assign prediction_taken   = prediction.taken;
	assign prediction_next_pc = prediction.next_pc;

endmodule

// File: tb/branch_predictor_sva.sv
// output checks for branch_predictor_top, attached by bind
// counts unresolved predictions itself, good for up to 15 in flight

`timescale 1ns/1ps

module branch_predictor_sva (
	input logic clock,
	input logic reset,
	input logic prediction_valid,
	input logic resolve_valid,
	input logic mispredict,
	input logic queue_full
);

	logic [3:0] in_flight; // predictions not yet resolved

	always_ff @(posedge clock) begin
		if (reset || mispredict) begin
			in_flight <= '0; // mispredict flushes everything younger
		end else begin
			in_flight <= in_flight + {3'b0, prediction_valid}
				- {3'b0, resolve_valid && (in_flight != '0)};
		end
	end

	mispredict_needs_prediction: assert property (@(posedge clock) disable iff (reset)
		mispredict |-> (in_flight != '0))
		else $error("mispredict with no unresolved prediction");

	no_predict_on_mispredict: assert property (@(posedge clock) disable iff (reset)
		!(prediction_valid && mispredict))
		else $error("prediction_valid in a mispredict cycle");

	full_blocks_predict: assert property (@(posedge clock) disable iff (reset)
		queue_full |-> !prediction_valid)
		else $error("prediction_valid while queue_full");

endmodule

bind branch_predictor_top branch_predictor_sva branch_predictor_sva_inst (
	.clock            (clock),
	.reset            (reset),
	.prediction_valid (prediction_valid),
	.resolve_valid    (resolve_valid),
	.mispredict       (mispredict),
	.queue_full       (queue_full)
);

// File: tb/branch_predictor_tb.sv
// directed and seeded random tests for the gshare predictor top level
// the model keeps one-bit table entries and assumes resolutions come in program order

`timescale 1ns/1ps
`include "bp_macros.svh"

module branch_predictor_tb;

	localparam int RESET_CYCLES    = 3;
	localparam int DIRECTED_CYCLES = 80;  // five directed tests need about 60
	localparam int RANDOM_CYCLES   = 200;
	localparam int TIMEOUT_CYCLES  = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 100;
	localparam logic [31:0] ADDI_X1 = 32'h0010_0093; // addi x1, x0, 1

	logic             clock = 1'b0;
	logic             reset;
	logic             fetch_valid;
	logic [`XLEN-1:0] fetch_pc;
	logic [`XLEN-1:0] fetch_instr;
	logic             resolve_valid;
	logic             resolve_taken;
	logic             prediction_valid;
	logic             prediction_taken;
	logic [`XLEN-1:0] prediction_next_pc;
	logic             mispredict;
	logic [`XLEN-1:0] redirect_pc;
	logic             queue_full;

	// reference model state
	logic [(1<<`BH_SIZE)-1:0] pht_m;
	logic [`BH_SIZE-1:0]      ghr_m;
	logic [`XLEN-1:0]         q_pc[$];
	logic [`BH_SIZE-1:0]      q_hist[$];   // checkpoint per entry
	logic                     q_taken[$];
	logic [`XLEN-1:0]         q_target[$];
	logic                     pend_valid;  // decoded branch waiting for its prediction cycle
	logic [`XLEN-1:0]         pend_pc;
	logic [`XLEN-1:0]         pend_target;

	// outputs seen in the last cycle
	logic             last_pv;
	logic             last_taken;
	logic             last_mis;
	logic             last_full;
	logic [`XLEN-1:0] last_next;
	logic [`XLEN-1:0] last_redirect;

	int     errors      = 0;
	int     checks      = 0;
	int     tests       = 0;
	int     cycle_count = 0;
	integer seed        = 32'h11bf;

	branch_predictor_top branch_predictor_top_inst (
		.clock              (clock),
		.reset              (reset),
		.fetch_valid        (fetch_valid),
		.fetch_pc           (fetch_pc),
		.fetch_instr        (fetch_instr),
		.resolve_valid      (resolve_valid),
		.resolve_taken      (resolve_taken),
		.prediction_valid   (prediction_valid),
		.prediction_taken   (prediction_taken),
		.prediction_next_pc (prediction_next_pc),
		.mispredict         (mispredict),
		.redirect_pc        (redirect_pc),
		.queue_full         (queue_full)
	);

	always #4 clock = ~clock; // 8 ns period

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
			$display("Some tests failed");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("FAIL time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
		end
	endtask

	// beq-family word with x1/x2, offset is a byte count with bit 0 ignored
	function automatic logic [31:0] encode_branch(input logic [12:0] off);
		return {off[12], off[10:5], 5'd2, 5'd1, 3'b001, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] branch_offset(input logic [31:0] w);
		return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
	endfunction

	// called on a falling edge, drives one cycle, checks it and steps the model
	task automatic run_cycle(input logic fv, input logic [31:0] pc, input logic [31:0] instr,
			input logic rv, input logic rt);
		logic             exp_full;
		logic             exp_mis;
		logic             exp_pv;
		logic             exp_taken;
		logic [31:0]      head_pc;
		logic [`BH_SIZE-1:0] head_hist;
		fetch_valid   = fv;
		fetch_pc      = pc;
		fetch_instr   = instr;
		resolve_valid = rv;
		resolve_taken = rt;
		#1;
		head_pc   = (q_pc.size() > 0) ? q_pc[0] : '0;
		head_hist = (q_pc.size() > 0) ? q_hist[0] : '0;
		exp_full  = (q_pc.size() == `OBQ_DEPTH);
		exp_mis   = rv && (q_pc.size() > 0) && (rt != q_taken[0]);
		exp_pv    = pend_valid && !exp_full && !exp_mis; // rollback wins over a new branch
		exp_taken = pht_m[ghr_m ^ pend_pc[`BH_SIZE+1:2]];
		check_value("queue_full", exp_full, queue_full);
		check_value("mispredict", exp_mis, mispredict);
		check_value("prediction_valid", exp_pv, prediction_valid);
		if (exp_pv) begin
			check_value("prediction_taken", exp_taken, prediction_taken);
			check_value("prediction_next_pc", exp_taken ? pend_target : pend_pc + 32'd4,
				prediction_next_pc);
		end
		if (exp_mis)
			check_value("redirect_pc", rt ? q_target[0] : head_pc + 32'd4, redirect_pc);
		last_pv       = prediction_valid;
		last_taken    = prediction_taken;
		last_next     = prediction_next_pc;
		last_mis      = mispredict;
		last_redirect = redirect_pc;
		last_full     = queue_full;
		if (exp_mis) begin
			pht_m[head_hist ^ head_pc[`BH_SIZE+1:2]] = ~pht_m[head_hist ^ head_pc[`BH_SIZE+1:2]];
			ghr_m = {head_hist[`BH_SIZE-2:0], rt};
			q_pc.delete();
			q_hist.delete();
			q_taken.delete();
			q_target.delete(); // whole queue flushed
		end else begin
			if (rv && q_pc.size() > 0) begin
				void'(q_pc.pop_front());
				void'(q_hist.pop_front());
				void'(q_taken.pop_front());
				void'(q_target.pop_front());
			end
			if (exp_pv) begin
				q_pc.push_back(pend_pc);
				q_hist.push_back(ghr_m);
				q_taken.push_back(exp_taken);
				q_target.push_back(pend_target);
				ghr_m = {ghr_m[`BH_SIZE-2:0], exp_taken};
			end
		end
		pend_valid  = fv && (instr[6:0] == 7'b1100011);
		pend_pc     = pc;
		pend_target = pc + branch_offset(instr);
		@(negedge clock);
	endtask

	// resolve everything left with its predicted outcome, so no mispredicts
	task automatic drain_queue();
		while (pend_valid || q_pc.size() > 0) begin
			if (q_pc.size() > 0)
				run_cycle(1'b0, '0, '0, 1'b1, q_taken[0]);
			else
				run_cycle(1'b0, '0, '0, 1'b0, 1'b0);
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests++;
		$display("test %s done, %0d errors", name, errors - errors_before);
	endtask

	task automatic reset_not_taken();
		int start;
		start = errors;
		run_cycle(1'b1, 32'h200, encode_branch(13'd32), 1'b0, 1'b0);
		run_cycle(1'b1, 32'h204, encode_branch(13'h1ff0), 1'b0, 1'b0); // backward branch
		check_value("prediction_valid", 1, last_pv);
		check_value("prediction_taken", 0, last_taken);
		check_value("prediction_next_pc", 32'h204, last_next);
		run_cycle(1'b0, '0, '0, 1'b0, 1'b0);
		check_value("prediction_next_pc", 32'h208, last_next);
		drain_queue();
		report_test("reset_not_taken", start);
	endtask

	task automatic non_branch_ignored();
		int start;
		start = errors;
		run_cycle(1'b1, 32'h400, ADDI_X1, 1'b0, 1'b0);
		run_cycle(1'b1, 32'h404, 32'h0080_006f, 1'b0, 1'b0); // jal is not a conditional branch
		check_value("prediction_valid", 0, last_pv);
		run_cycle(1'b0, '0, '0, 1'b0, 1'b0);
		check_value("prediction_valid", 0, last_pv);
		report_test("non_branch_ignored", start);
	endtask

	task automatic mispredict_redirect();
		int start;
		start = errors;
		run_cycle(1'b1, 32'h100, encode_branch(13'd64), 1'b0, 1'b0);
		run_cycle(1'b0, '0, '0, 1'b0, 1'b0);
		check_value("prediction_taken", 0, last_taken);
		run_cycle(1'b0, '0, '0, 1'b1, 1'b1);
		check_value("mispredict", 1, last_mis);
		check_value("redirect_pc", 32'h140, last_redirect);
		// eight not-taken fillers bring the history back to the checkpoint
		for (int i = 0; i < 8; i++) begin
			run_cycle(1'b1, 32'h40c, encode_branch(13'd8), i != 0, 1'b0);
			run_cycle(1'b0, '0, '0, 1'b0, 1'b0);
		end
		drain_queue();
		run_cycle(1'b1, 32'h100, encode_branch(13'd64), 1'b0, 1'b0);
		run_cycle(1'b0, '0, '0, 1'b0, 1'b0);
		check_value("prediction_valid", 1, last_pv);
		check_value("prediction_taken", 1, last_taken);
		check_value("prediction_next_pc", 32'h140, last_next);
		drain_queue();
		report_test("mispredict_redirect", start);
	endtask

	task automatic flush_younger();
		int start;
		start = errors;
		for (int i = 0; i < 3; i++)
			run_cycle(1'b1, 32'h500 + 4 * i, encode_branch(13'd16), 1'b0, 1'b0);
		run_cycle(1'b0, '0, '0, 1'b0, 1'b0);
		run_cycle(1'b0, '0, '0, 1'b1, ~q_taken[0]);
		check_value("mispredict", 1, last_mis);
		run_cycle(1'b0, '0, '0, 1'b1, 1'b0); // younger entries are gone
		check_value("mispredict", 0, last_mis);
		run_cycle(1'b0, '0, '0, 1'b1, 1'b1);
		check_value("mispredict", 0, last_mis);
		run_cycle(1'b1, 32'h600, encode_branch(13'd16), 1'b0, 1'b0);
		run_cycle(1'b0, '0, '0, 1'b0, 1'b0);
		run_cycle(1'b0, '0, '0, 1'b1, ~q_taken[0]);
		check_value("mispredict", 1, last_mis);
		report_test("flush_younger", start);
	endtask

	task automatic full_queue_drop();
		int                  start;
		logic [`BH_SIZE-1:0] ghr_before;
		start = errors;
		for (int i = 0; i <= `OBQ_DEPTH; i++)
			run_cycle(1'b1, 32'h700 + 4 * i, encode_branch(13'd24), 1'b0, 1'b0);
		ghr_before = ghr_m;
		run_cycle(1'b0, '0, '0, 1'b0, 1'b0); // last fetch meets a full queue
		check_value("queue_full", 1, last_full);
		check_value("prediction_valid", 0, last_pv);
		check_value("ghr", ghr_before, branch_predictor_top_inst.gshare_predictor_inst.ghr);
		drain_queue();
		report_test("full_queue_drop", start);
	endtask

	task automatic random_stream();
		int          start;
		logic [31:0] r;
		logic [31:0] r2;
		logic [31:0] instr;
		start = errors;
		for (int i = 0; i < RANDOM_CYCLES; i++) begin
			r     = $random(seed);
			r2    = $random(seed);
			instr = (r[3] | r[4]) ? encode_branch({r2[22:11], 1'b0}) : ADDI_X1; // 3 in 4 branch
			run_cycle(r[0], {16'h0001, 6'd0, r2[9:2], 2'b00}, instr, r[1], r[2]);
		end
		drain_queue();
		report_test("random_stream", start);
	endtask

	initial begin
		reset         = 1'b1;
		fetch_valid   = 1'b0;
		fetch_pc      = '0;
		fetch_instr   = '0;
		resolve_valid = 1'b0;
		resolve_taken = 1'b0;
		pht_m         = '0;
		ghr_m         = '0;
		pend_valid    = 1'b0;
		pend_pc       = '0;
		pend_target   = '0;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		reset_not_taken();
		non_branch_ignored();
		mispredict_redirect();
		flush_younger();
		full_queue_drop();
		random_stream();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: branch_predictor.f
+incdir+logic
logic/bp_pkg.sv
logic/branch_decoder.sv
logic/gshare_predictor.sv
logic/branch_queue.sv
logic/branch_predictor_top.sv
tb/branch_predictor_sva.sv
tb/branch_predictor_tb.sv

// File: Makefile
# Verilator build and run for the gshare branch predictor
# override any variable on the command line, e.g. make OBJ_DIR=build

VERILATOR  ?= verilator
TOP        ?= branch_predictor_tb
RTL_TOP    ?= branch_predictor_top
FILELIST   ?= branch_predictor.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall
RTL_FILES  ?= logic/bp_pkg.sv logic/branch_decoder.sv logic/gshare_predictor.sv \
              logic/branch_queue.sv logic/branch_predictor_top.sv
PASS_MSG   ?= All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) +incdir+logic --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(OBJ_DIR)
